//--- src/eth_router_defs.svh
`ifndef ETH_ROUTER_DEFS_SVH
`define ETH_ROUTER_DEFS_SVH

// Datapath and header field widths
`define ETH_DATA_WIDTH 8
`define ETH_MAC_WIDTH 48
`define ETH_TYPE_WIDTH 16

// EtherType codes
`define ETHERTYPE_IPV4 16'h0800
`define ETHERTYPE_ARP 16'h0806

// Transmit sources into the MAC arbiter, ARP on port 0
`define ETH_ARB_PORTS 2

`endif

//--- src/eth_router_pkg.sv
`default_nettype none

package eth_router_pkg;

  `include "eth_router_defs.svh"

  // Ethernet frame header, MSB first as on the wire
  typedef struct packed {
    logic [`ETH_MAC_WIDTH-1:0]  dest_mac;
    logic [`ETH_MAC_WIDTH-1:0]  src_mac;
    logic [`ETH_TYPE_WIDTH-1:0] eth_type;
  } eth_hdr_t;

  // One payload beat
  typedef struct packed {
    logic [`ETH_DATA_WIDTH-1:0] data;
    logic                       last;
    logic                       user;
  } eth_beat_t;

  // Receive steering target
  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_IP,
    ROUTE_ARP,
    ROUTE_DROP
  } route_t;

  // Transmit arbiter phase
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_HDR,
    ARB_PAYLOAD
  } arb_state_t;

endpackage

`default_nettype wire

//--- src/ethertype_demux.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_router_defs.svh"

module ethertype_demux
  import eth_router_pkg::*;
(
  input  wire            clk,
  input  wire            rst,

  input  wire            rx_hdr_valid,
  input  wire eth_hdr_t  rx_hdr,
  output logic           rx_hdr_ready,
  input  wire            rx_valid,
  input  wire eth_beat_t rx_beat,
  output logic           rx_ready,

  output logic           ip_hdr_valid,
  input  wire            ip_hdr_ready,
  output logic           ip_valid,
  input  wire            ip_ready,

  output logic           arp_hdr_valid,
  input  wire            arp_hdr_ready,
  output logic           arp_valid,
  input  wire            arp_ready,

  output eth_hdr_t       out_hdr,
  output eth_beat_t      out_beat
);

  route_t route_q;
  route_t hdr_route;
  logic   idle;
  logic   hdr_xfer;
  logic   last_xfer;

  // Classify the header currently presented
  always_comb begin
    if (rx_hdr.eth_type == `ETHERTYPE_IPV4) begin
      hdr_route = ROUTE_IP;
    end else if (rx_hdr.eth_type == `ETHERTYPE_ARP) begin
      hdr_route = ROUTE_ARP;
    end else begin
      hdr_route = ROUTE_DROP;
    end
  end

  assign idle = (route_q == ROUTE_IDLE);

  // Header accepted only between frames
  assign rx_hdr_ready = idle && (((hdr_route == ROUTE_IP) && ip_hdr_ready) ||
                                 ((hdr_route == ROUTE_ARP) && arp_hdr_ready) ||
                                 (hdr_route == ROUTE_DROP));

  assign ip_hdr_valid  = idle && rx_hdr_valid && (hdr_route == ROUTE_IP);
  assign arp_hdr_valid = idle && rx_hdr_valid && (hdr_route == ROUTE_ARP);

  assign ip_valid  = (route_q == ROUTE_IP) && rx_valid;
  assign arp_valid = (route_q == ROUTE_ARP) && rx_valid;

  // Dropped frames are sunk at full rate
  assign rx_ready = ((route_q == ROUTE_IP) && ip_ready) ||
                    ((route_q == ROUTE_ARP) && arp_ready) ||
                    (route_q == ROUTE_DROP);

  assign out_hdr  = rx_hdr;
  assign out_beat = rx_beat;

  assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
  assign last_xfer = rx_valid && rx_ready && rx_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= ROUTE_IDLE;
    end else if (hdr_xfer) begin
      route_q <= hdr_route;
    end else if (last_xfer) begin
      route_q <= ROUTE_IDLE;
    end
  end

endmodule

`default_nettype wire

//--- src/axis_skid_register.sv
`timescale 1ns/1ns
`default_nettype none

module axis_skid_register
  import eth_router_pkg::*;
(
  input  wire            clk,
  input  wire            rst,

  input  wire            in_valid,
  input  wire eth_beat_t in_beat,
  output logic           in_ready,

  output logic           out_valid,
  output eth_beat_t      out_beat,
  input  wire            out_ready
);

  logic      out_valid_q;
  eth_beat_t out_beat_q;
  logic      skid_valid_q;
  eth_beat_t skid_beat_q;
  logic      out_free;
  logic      in_xfer;

  // Skid slot occupied means upstream must wait
  assign in_ready  = !skid_valid_q;
  assign out_valid = out_valid_q;
  assign out_beat  = out_beat_q;

  assign out_free = out_ready || !out_valid_q;
  assign in_xfer  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      if (skid_valid_q) begin
        out_valid_q  <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        out_valid_q <= in_valid;
      end
    end else if (in_xfer) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid_q) begin
        out_beat_q <= skid_beat_q;
      end else if (in_valid) begin
        out_beat_q <= in_beat;
      end
    end else if (in_xfer) begin
      skid_beat_q <= in_beat;
    end
  end

endmodule

`default_nettype wire

//--- src/eth_frame_arb.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_router_defs.svh"

module eth_frame_arb
  import eth_router_pkg::*;
(
  input  wire                                    clk,
  input  wire                                    rst,

  input  wire [`ETH_ARB_PORTS-1:0]               src_hdr_valid,
  input  wire eth_hdr_t [`ETH_ARB_PORTS-1:0]     src_hdr,
  output logic [`ETH_ARB_PORTS-1:0]              src_hdr_ready,
  input  wire [`ETH_ARB_PORTS-1:0]               src_valid,
  input  wire eth_beat_t [`ETH_ARB_PORTS-1:0]    src_beat,
  output logic [`ETH_ARB_PORTS-1:0]              src_ready,

  output logic                                   mac_hdr_valid,
  output eth_hdr_t                               mac_hdr,
  input  wire                                    mac_hdr_ready,
  output logic                                   mac_valid,
  output eth_beat_t                              mac_beat,
  input  wire                                    mac_ready
);

  localparam int SEL_W = (`ETH_ARB_PORTS > 1) ? $clog2(`ETH_ARB_PORTS) : 1;

  arb_state_t       state_q;
  logic [SEL_W-1:0] grant_q;
  eth_hdr_t         hdr_q;
  logic [SEL_W-1:0] req_idx;
  logic             req_any;
  logic             hdr_xfer;
  logic             last_xfer;

  // Lowest index wins
  always_comb begin
    req_any = 1'b0;
    req_idx = '0;
    for (int i = `ETH_ARB_PORTS - 1; i >= 0; i--) begin
      if (src_hdr_valid[i]) begin
        req_any = 1'b1;
        req_idx = SEL_W'(i);
      end
    end
  end

  // Only the granted source sees ready, the rest stall
  always_comb begin
    for (int i = 0; i < `ETH_ARB_PORTS; i++) begin
      src_hdr_ready[i] = (state_q == ARB_IDLE) && req_any && (req_idx == SEL_W'(i));
      src_ready[i]     = (state_q == ARB_PAYLOAD) && (grant_q == SEL_W'(i)) && mac_ready;
    end
  end

  assign hdr_xfer = (state_q == ARB_IDLE) && req_any;

  assign mac_hdr_valid = (state_q == ARB_HDR);
  assign mac_hdr       = hdr_q;

  // Payload path is combinational once the header has gone out
  assign mac_valid = (state_q == ARB_PAYLOAD) && src_valid[grant_q];
  assign mac_beat  = src_beat[grant_q];

  assign last_xfer = mac_valid && mac_ready && mac_beat.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (hdr_xfer) begin
            state_q <= ARB_HDR;
            grant_q <= req_idx;
          end
        end
        ARB_HDR: begin
          if (mac_hdr_ready) begin
            state_q <= ARB_PAYLOAD;
          end
        end
        ARB_PAYLOAD: begin
          // Grant held until the frame ends
          if (last_xfer) begin
            state_q <= ARB_IDLE;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_xfer) begin
      hdr_q <= src_hdr[req_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/eth_router.sv
`timescale 1ns/1ns
`default_nettype none

module eth_router
  import eth_router_pkg::*;
(
  input  wire            clk,
  input  wire            rst,

  // From the MAC
  input  wire            rx_hdr_valid,
  input  wire eth_hdr_t  rx_hdr,
  output logic           rx_hdr_ready,
  input  wire            rx_valid,
  input  wire eth_beat_t rx_beat,
  output logic           rx_ready,

  // To the IP engine
  output logic           ip_rx_hdr_valid,
  output eth_hdr_t       ip_rx_hdr,
  input  wire            ip_rx_hdr_ready,
  output logic           ip_rx_valid,
  output eth_beat_t      ip_rx_beat,
  input  wire            ip_rx_ready,

  // To the ARP engine
  output logic           arp_rx_hdr_valid,
  output eth_hdr_t       arp_rx_hdr,
  input  wire            arp_rx_hdr_ready,
  output logic           arp_rx_valid,
  output eth_beat_t      arp_rx_beat,
  input  wire            arp_rx_ready,

  // From the IP engine
  input  wire            ip_tx_hdr_valid,
  input  wire eth_hdr_t  ip_tx_hdr,
  output logic           ip_tx_hdr_ready,
  input  wire            ip_tx_valid,
  input  wire eth_beat_t ip_tx_beat,
  output logic           ip_tx_ready,

  // From the ARP engine
  input  wire            arp_tx_hdr_valid,
  input  wire eth_hdr_t  arp_tx_hdr,
  output logic           arp_tx_hdr_ready,
  input  wire            arp_tx_valid,
  input  wire eth_beat_t arp_tx_beat,
  output logic           arp_tx_ready,

  // To the MAC
  output logic           mac_tx_hdr_valid,
  output eth_hdr_t       mac_tx_hdr,
  input  wire            mac_tx_hdr_ready,
  output logic           mac_tx_valid,
  output eth_beat_t      mac_tx_beat,
  input  wire            mac_tx_ready
);

  eth_hdr_t  rx_out_hdr;
  eth_beat_t rx_out_beat;
  logic      arp_skid_valid;
  eth_beat_t arp_skid_beat;
  logic      arp_skid_ready;

  // Both engines see the same header and beat, valids are qualified
  assign ip_rx_hdr   = rx_out_hdr;
  assign arp_rx_hdr  = rx_out_hdr;
  assign ip_rx_beat  = rx_out_beat;
  assign arp_rx_beat = rx_out_beat;

  ethertype_demux rx_demux (
    .clk          (clk),
    .rst          (rst),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_hdr       (rx_hdr),
    .rx_hdr_ready (rx_hdr_ready),
    .rx_valid     (rx_valid),
    .rx_beat      (rx_beat),
    .rx_ready     (rx_ready),
    .ip_hdr_valid (ip_rx_hdr_valid),
    .ip_hdr_ready (ip_rx_hdr_ready),
    .ip_valid     (ip_rx_valid),
    .ip_ready     (ip_rx_ready),
    .arp_hdr_valid(arp_rx_hdr_valid),
    .arp_hdr_ready(arp_rx_hdr_ready),
    .arp_valid    (arp_rx_valid),
    .arp_ready    (arp_rx_ready),
    .out_hdr      (rx_out_hdr),
    .out_beat     (rx_out_beat)
  );

  axis_skid_register arp_tx_skid (
    .clk      (clk),
    .rst      (rst),
    .in_valid (arp_tx_valid),
    .in_beat  (arp_tx_beat),
    .in_ready (arp_tx_ready),
    .out_valid(arp_skid_valid),
    .out_beat (arp_skid_beat),
    .out_ready(arp_skid_ready)
  );

  // Port 0 is ARP and has priority
  eth_frame_arb tx_arb (
    .clk          (clk),
    .rst          (rst),
    .src_hdr_valid({ip_tx_hdr_valid, arp_tx_hdr_valid}),
    .src_hdr      ({ip_tx_hdr, arp_tx_hdr}),
    .src_hdr_ready({ip_tx_hdr_ready, arp_tx_hdr_ready}),
    .src_valid    ({ip_tx_valid, arp_skid_valid}),
    .src_beat     ({ip_tx_beat, arp_skid_beat}),
    .src_ready    ({ip_tx_ready, arp_skid_ready}),
    .mac_hdr_valid(mac_tx_hdr_valid),
    .mac_hdr      (mac_tx_hdr),
    .mac_hdr_ready(mac_tx_hdr_ready),
    .mac_valid    (mac_tx_valid),
    .mac_beat     (mac_tx_beat),
    .mac_ready    (mac_tx_ready)
  );

endmodule

`default_nettype wire

//--- testbench/tb_eth_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_router_defs.svh"

module tb_eth_router
  import eth_router_pkg::*;
;

  localparam int MAX_CYCLES = 4000;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic rx_hdr_valid = 1'b0, rx_valid = 1'b0;
  logic ip_tx_hdr_valid = 1'b0, ip_tx_valid = 1'b0;
  logic arp_tx_hdr_valid = 1'b0, arp_tx_valid = 1'b0;
  logic ip_rx_hdr_ready = 1'b1, arp_rx_hdr_ready = 1'b1, mac_tx_hdr_ready = 1'b1;
  logic ip_rx_ready = 1'b0, arp_rx_ready = 1'b0, mac_tx_ready = 1'b0;
  eth_hdr_t rx_hdr = '0, ip_tx_hdr = '0, arp_tx_hdr = '0;
  eth_beat_t rx_beat = '0, ip_tx_beat = '0, arp_tx_beat = '0;
  logic rx_hdr_ready, rx_ready, ip_tx_hdr_ready, ip_tx_ready, arp_tx_hdr_ready, arp_tx_ready;
  logic ip_rx_hdr_valid, ip_rx_valid, arp_rx_hdr_valid, arp_rx_valid;
  logic mac_tx_hdr_valid, mac_tx_valid;
  eth_hdr_t ip_rx_hdr, arp_rx_hdr, mac_tx_hdr;
  eth_beat_t ip_rx_beat, arp_rx_beat, mac_tx_beat;

  eth_router dut (.*);

  // Frame slots built from LFSR bytes
  eth_hdr_t  frame_hdr [4];
  eth_beat_t frame_beat [4][16];
  int        frame_len [4];

  eth_hdr_t  exp_ip_hdr[$], exp_arp_hdr[$], exp_mac_hdr[$];
  eth_beat_t exp_ip_beat[$], exp_arp_beat[$], exp_mac_beat[$];

  logic [31:0] data_lfsr = 32'h76dffef9;
  logic [31:0] ready_lfsr = 32'h76dffef9;
  logic        rand_ready = 1'b0;
  string       test_name = "reset";
  int          err_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;

  initial begin
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[30:0], data_lfsr[0]};
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycles, test_name);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Back-pressure on the ip_rx and mac_tx channels
  always @(posedge clk) begin
    arp_rx_ready <= 1'b1;
    if (rand_ready) begin
      ready_lfsr = lfsr_next(ready_lfsr);
      ip_rx_ready <= ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      mac_tx_ready <= ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      ip_rx_hdr_ready <= ready_lfsr[0];
      ready_lfsr = lfsr_next(ready_lfsr);
      mac_tx_hdr_ready <= ready_lfsr[0];
    end else begin
      ip_rx_ready <= 1'b1;
      mac_tx_ready <= 1'b1;
      ip_rx_hdr_ready <= 1'b1;
      mac_tx_hdr_ready <= 1'b1;
    end
  end

  task automatic check_value(input string what, input logic [111:0] exp, input logic [111:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic unexpected(input string what);
    $display("Test %s saw an unexpected transfer on %s", test_name, what);
    err_count++;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (ip_rx_hdr_valid && ip_rx_hdr_ready) begin
        if (exp_ip_hdr.size() == 0) unexpected("ip_rx header");
        else check_value("ip_rx header", exp_ip_hdr.pop_front(), ip_rx_hdr);
      end
      if (ip_rx_valid && ip_rx_ready) begin
        if (exp_ip_beat.size() == 0) unexpected("ip_rx payload");
        else check_value("ip_rx beat", 112'(exp_ip_beat.pop_front()), 112'(ip_rx_beat));
      end
      if (arp_rx_hdr_valid && arp_rx_hdr_ready) begin
        if (exp_arp_hdr.size() == 0) unexpected("arp_rx header");
        else check_value("arp_rx header", exp_arp_hdr.pop_front(), arp_rx_hdr);
      end
      if (arp_rx_valid && arp_rx_ready) begin
        if (exp_arp_beat.size() == 0) unexpected("arp_rx payload");
        else check_value("arp_rx beat", 112'(exp_arp_beat.pop_front()), 112'(arp_rx_beat));
      end
      if (mac_tx_hdr_valid && mac_tx_hdr_ready) begin
        if (exp_mac_hdr.size() == 0) unexpected("mac_tx header");
        else check_value("mac_tx header", exp_mac_hdr.pop_front(), mac_tx_hdr);
      end
      if (mac_tx_valid && mac_tx_ready) begin
        if (exp_mac_beat.size() == 0) unexpected("mac_tx payload");
        else check_value("mac_tx beat", 112'(exp_mac_beat.pop_front()), 112'(mac_tx_beat));
      end
    end
  end

  task automatic make_frame(input int slot, input logic [15:0] eth_type, input int len);
    logic [31:0] a, b, c, d;
    take_bits(24, a);
    take_bits(24, b);
    take_bits(24, c);
    take_bits(24, d);
    frame_hdr[slot] = '{dest_mac: {a[23:0], b[23:0]}, src_mac: {c[23:0], d[23:0]},
                        eth_type: eth_type};
    frame_len[slot] = len;
    for (int i = 0; i < len; i++) begin
      take_bits(9, a);
      frame_beat[slot][i] = '{data: a[8:1], last: (i == len - 1), user: a[0]};
    end
  endtask

  // Port 0 ip_rx, 1 arp_rx, 2 mac_tx
  task automatic expect_frame(input int port, input int slot);
    for (int i = 0; i < frame_len[slot]; i++) begin
      if (port == 0) exp_ip_beat.push_back(frame_beat[slot][i]);
      else if (port == 1) exp_arp_beat.push_back(frame_beat[slot][i]);
      else exp_mac_beat.push_back(frame_beat[slot][i]);
    end
    if (port == 0) exp_ip_hdr.push_back(frame_hdr[slot]);
    else if (port == 1) exp_arp_hdr.push_back(frame_hdr[slot]);
    else exp_mac_hdr.push_back(frame_hdr[slot]);
  endtask

  task automatic send_rx(input int slot);
    @(posedge clk);
    rx_hdr_valid <= 1'b1;
    rx_hdr <= frame_hdr[slot];
    do @(posedge clk); while (!rx_hdr_ready);
    rx_hdr_valid <= 1'b0;
    for (int i = 0; i < frame_len[slot]; i++) begin
      rx_valid <= 1'b1;
      rx_beat <= frame_beat[slot][i];
      do @(posedge clk); while (!rx_ready);
    end
    rx_valid <= 1'b0;
  endtask

  task automatic send_ip_tx(input int slot);
    @(posedge clk);
    ip_tx_hdr_valid <= 1'b1;
    ip_tx_hdr <= frame_hdr[slot];
    do @(posedge clk); while (!ip_tx_hdr_ready);
    ip_tx_hdr_valid <= 1'b0;
    for (int i = 0; i < frame_len[slot]; i++) begin
      ip_tx_valid <= 1'b1;
      ip_tx_beat <= frame_beat[slot][i];
      do @(posedge clk); while (!ip_tx_ready);
    end
    ip_tx_valid <= 1'b0;
  endtask

  task automatic send_arp_tx(input int slot);
    @(posedge clk);
    arp_tx_hdr_valid <= 1'b1;
    arp_tx_hdr <= frame_hdr[slot];
    do @(posedge clk); while (!arp_tx_hdr_ready);
    arp_tx_hdr_valid <= 1'b0;
    for (int i = 0; i < frame_len[slot]; i++) begin
      arp_tx_valid <= 1'b1;
      arp_tx_beat <= frame_beat[slot][i];
      do @(posedge clk); while (!arp_tx_ready);
    end
    arp_tx_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_ip_hdr.size() + exp_ip_beat.size() + exp_arp_hdr.size() +
           exp_arp_beat.size() + exp_mac_hdr.size() + exp_mac_beat.size() != 0) begin
      @(posedge clk);
    end
    // Room for stray outputs to show up
    repeat (4) @(posedge clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_count = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count != 0) tests_failed++;
    $display("%s: %s", test_name, (err_count == 0) ? "passed" : "failed");
  endtask

  task automatic test_ip_rx();
    start_test("ip_rx");
    make_frame(0, `ETHERTYPE_IPV4, 6);
    expect_frame(0, 0);
    send_rx(0);
    wait_drained();
    end_test();
  endtask

  task automatic test_arp_rx();
    start_test("arp_rx");
    make_frame(0, `ETHERTYPE_ARP, 5);
    expect_frame(1, 0);
    send_rx(0);
    wait_drained();
    end_test();
  endtask

  task automatic test_drop();
    start_test("drop");
    make_frame(0, 16'h86dd, 7);
    make_frame(1, `ETHERTYPE_IPV4, 4);
    send_rx(0);
    expect_frame(0, 1);
    send_rx(1);
    wait_drained();
    end_test();
  endtask

  task automatic test_tx_single();
    start_test("tx_single");
    make_frame(0, `ETHERTYPE_IPV4, 6);
    make_frame(1, `ETHERTYPE_ARP, 5);
    expect_frame(2, 0);
    send_ip_tx(0);
    wait_drained();
    expect_frame(2, 1);
    send_arp_tx(1);
    wait_drained();
    end_test();
  endtask

  task automatic test_tx_priority();
    start_test("tx_priority");
    make_frame(0, `ETHERTYPE_IPV4, 7);
    make_frame(1, `ETHERTYPE_ARP, 6);
    expect_frame(2, 1);
    expect_frame(2, 0);
    fork
      send_ip_tx(0);
      send_arp_tx(1);
    join
    wait_drained();
    end_test();
  endtask

  task automatic test_random_ready();
    start_test("random_ready");
    rand_ready <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      make_frame(i, (i % 2 == 0) ? `ETHERTYPE_IPV4 : `ETHERTYPE_ARP, 5 + i);
    end
    expect_frame(0, 0);
    expect_frame(1, 1);
    expect_frame(2, 3);
    expect_frame(2, 2);
    fork
      begin
        send_rx(0);
        send_rx(1);
      end
      send_ip_tx(2);
      send_arp_tx(3);
    join
    wait_drained();
    rand_ready <= 1'b0;
    end_test();
  endtask

  initial begin
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);
    test_ip_rx();
    test_arp_rx();
    test_drop();
    test_tx_single();
    test_tx_priority();
    test_random_ready();
    $display("Tests run %0d, failed %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/eth_router_pkg.sv
src/ethertype_demux.sv
src/axis_skid_register.sv
src/eth_frame_arb.sv
src/eth_router.sv
testbench/tb_eth_router.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_eth_router
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
